// ==== design/lsq_cfg_pkg.sv ====
package lsq_cfg_pkg;

  // Queue geometry
  localparam int NUM_ENTRIES = 8;
  localparam int IDX_W       = $clog2(NUM_ENTRIES);

  // Slot index plus wrap bit
  localparam int PTR_W       = IDX_W + 1;

  // Word widths
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;

  // Addresses compare at word granularity
  localparam int WORD_LSB    = 2;
  localparam int WADDR_W     = ADDR_W - WORD_LSB;

endpackage

// ==== design/lsq_op_pkg.sv ====
package lsq_op_pkg;

  // Kind of memory operation at dispatch and retire
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

endpackage

// ==== design/queue_pointers.sv ====
`timescale 1ns/1ps

module queue_pointers (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          alloc,
  input  logic                          free,
  input  logic                          rollback_en,
  input  logic [lsq_cfg_pkg::PTR_W-1:0] rollback_tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0] head,
  output logic [lsq_cfg_pkg::PTR_W-1:0] tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0] count,
  output logic                          full,
  output logic                          empty
);

  import lsq_cfg_pkg::*;

  logic [PTR_W-1:0] next_head;
  logic [PTR_W-1:0] next_tail;
  logic             same_slot;
  logic             same_wrap;

  // Wrap bit tells full from empty when the slots match
  assign same_slot = head[IDX_W-1:0] == tail[IDX_W-1:0];
  assign same_wrap = head[IDX_W] == tail[IDX_W];

  assign count = tail - head;
  assign full  = same_slot && !same_wrap;
  assign empty = same_slot && same_wrap;

  // Rollback wins over allocation
  always_comb begin
    next_tail = tail;
    if (rollback_en) begin
      next_tail = rollback_tail;
    end else if (alloc) begin
      next_tail = tail + 1'b1;
    end
  end

  always_comb begin
    next_head = head;
    if (free) begin
      next_head = head + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

endmodule

// ==== design/store_queue.sv ====
`timescale 1ns/1ps

module store_queue (
  input  logic                           clock,
  input  logic                           reset,
  input  lsq_op_pkg::mem_op_e            dispatch_op,
  input  logic                           dispatch_valid,
  input  logic                           st_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  st_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_cfg_pkg::DATA_W-1:0] st_exec_data,
  input  logic                           ld_exec_valid,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_exec_addr,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  ld_store_bound,
  input  logic                           retire_valid,
  input  lsq_op_pkg::mem_op_e            retire_op,
  input  logic                           rollback_en,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_sq_tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  sq_alloc_idx,
  output logic                           sq_ready,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  sq_head,
  output logic                           fwd_hit,
  output logic [lsq_cfg_pkg::DATA_W-1:0] fwd_data,
  output logic                           mem_rd_en,
  output logic [lsq_cfg_pkg::ADDR_W-1:0] mem_rd_addr,
  output logic                           mem_wr_en,
  output logic [lsq_cfg_pkg::ADDR_W-1:0] mem_wr_addr,
  output logic [lsq_cfg_pkg::DATA_W-1:0] mem_wr_data
);

  import lsq_cfg_pkg::*;
  import lsq_op_pkg::*;

  logic [NUM_ENTRIES-1:0] addr_valid;
  logic [WADDR_W-1:0]     word_addr [NUM_ENTRIES];
  logic [DATA_W-1:0]      data      [NUM_ENTRIES];

  logic                   alloc;
  logic                   retire_st;
  logic                   full;
  logic                   empty;
  logic [PTR_W-1:0]       count;
  logic [IDX_W-1:0]       tail_idx;
  logic [IDX_W-1:0]       head_idx;
  logic [IDX_W-1:0]       exec_idx;
  logic [PTR_W-1:0]       bound_dist;
  logic [WADDR_W-1:0]     ld_word;
  logic                   hit;
  logic [DATA_W-1:0]      hit_data;

  assign alloc     = dispatch_valid && dispatch_op == MEM_STORE && !full && !rollback_en;
  assign retire_st = retire_valid && retire_op == MEM_STORE;

  queue_pointers ptr_i (
    .clock         (clock),
    .reset         (reset),
    .alloc         (alloc),
    .free          (retire_st && !empty),
    .rollback_en   (rollback_en),
    .rollback_tail (rollback_sq_tail),
    .head          (sq_head),
    .tail          (sq_alloc_idx),
    .count         (count),
    .full          (full),
    .empty         (empty)
  );

  assign sq_ready = !full;
  assign tail_idx = sq_alloc_idx[IDX_W-1:0];
  assign head_idx = sq_head[IDX_W-1:0];
  assign exec_idx = st_exec_idx[IDX_W-1:0];

  // Stores older than the load sit between head and its bound
  assign bound_dist = ld_store_bound - sq_head;
  assign ld_word    = ld_exec_addr[ADDR_W-1:WORD_LSB];

  // Walk oldest first so the last match is the youngest
  always_comb begin : fwd_search
    logic [IDX_W-1:0] slot;
    hit      = 1'b0;
    hit_data = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      slot = head_idx + IDX_W'(i);
      if (PTR_W'(i) < bound_dist && PTR_W'(i) < count && addr_valid[slot] &&
          word_addr[slot] == ld_word) begin
        hit      = 1'b1;
        hit_data = data[slot];
      end
    end
  end

  assign fwd_hit     = ld_exec_valid && hit;
  assign fwd_data    = hit_data;
  assign mem_rd_en   = ld_exec_valid && !hit;
  assign mem_rd_addr = ld_exec_addr;

  // Head entry goes out on a store retire
  assign mem_wr_en   = retire_st;
  assign mem_wr_addr = {word_addr[head_idx], {WORD_LSB{1'b0}}};
  assign mem_wr_data = data[head_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      addr_valid <= '0;
    end else begin
      if (alloc) begin
        addr_valid[tail_idx] <= 1'b0;
      end
      if (st_exec_valid) begin
        addr_valid[exec_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (st_exec_valid) begin
      word_addr[exec_idx] <= st_exec_addr[ADDR_W-1:WORD_LSB];
      data[exec_idx]      <= st_exec_data;
    end
  end

endmodule

// ==== design/load_queue.sv ====
`timescale 1ns/1ps

module load_queue (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  lsq_op_pkg::mem_op_e            dispatch_op,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  sq_alloc_idx,
  input  logic                           ld_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  ld_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_exec_addr,
  input  logic                           st_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  st_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  sq_head,
  input  logic                           retire_valid,
  input  lsq_op_pkg::mem_op_e            retire_op,
  input  logic                           rollback_en,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_lq_tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  lq_alloc_idx,
  output logic                           lq_ready,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  ld_store_bound,
  output logic                           violation,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  violation_lq_idx
);

  import lsq_cfg_pkg::*;
  import lsq_op_pkg::*;

  logic [NUM_ENTRIES-1:0] executed;
  logic [WADDR_W-1:0]     word_addr [NUM_ENTRIES];
  logic [PTR_W-1:0]       age_bound [NUM_ENTRIES];

  logic                   alloc;
  logic                   full;
  logic                   empty;
  logic [PTR_W-1:0]       lq_head;
  logic [PTR_W-1:0]       count;
  logic [IDX_W-1:0]       tail_idx;
  logic [IDX_W-1:0]       exec_idx;
  logic [PTR_W-1:0]       store_dist;
  logic [WADDR_W-1:0]     st_word;
  logic                   found;
  logic [PTR_W-1:0]       found_idx;

  assign alloc = dispatch_valid && dispatch_op == MEM_LOAD && !full && !rollback_en;

  queue_pointers ptr_i (
    .clock         (clock),
    .reset         (reset),
    .alloc         (alloc),
    .free          (retire_valid && retire_op == MEM_LOAD && !empty),
    .rollback_en   (rollback_en),
    .rollback_tail (rollback_lq_tail),
    .head          (lq_head),
    .tail          (lq_alloc_idx),
    .count         (count),
    .full          (full),
    .empty         (empty)
  );

  assign lq_ready = !full;
  assign tail_idx = lq_alloc_idx[IDX_W-1:0];
  assign exec_idx = ld_exec_idx[IDX_W-1:0];

  // Age bound of the executing load goes to the store queue
  assign ld_store_bound = age_bound[exec_idx];

  assign store_dist = st_exec_idx - sq_head;
  assign st_word    = st_exec_addr[ADDR_W-1:WORD_LSB];

  // Walk youngest to oldest so the oldest offender is kept
  always_comb begin : viol_search
    logic [IDX_W-1:0] slot;
    logic [PTR_W-1:0] load_dist;
    found     = 1'b0;
    found_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      slot      = lq_head[IDX_W-1:0] + IDX_W'(i);
      load_dist = age_bound[slot] - sq_head;
      // Load is younger if its bound lies past the store
      if (PTR_W'(i) < count && executed[slot] && word_addr[slot] == st_word &&
          store_dist < load_dist) begin
        found     = 1'b1;
        found_idx = lq_head + PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      violation        <= 1'b0;
      violation_lq_idx <= '0;
    end else begin
      violation        <= st_exec_valid && found;
      violation_lq_idx <= found_idx;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      executed <= '0;
    end else begin
      if (alloc) begin
        executed[tail_idx] <= 1'b0;
      end
      if (ld_exec_valid) begin
        executed[exec_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      age_bound[tail_idx] <= sq_alloc_idx;
    end
    if (ld_exec_valid) begin
      word_addr[exec_idx] <= ld_exec_addr[ADDR_W-1:WORD_LSB];
    end
  end

endmodule

// ==== design/lsq_top.sv ====
`timescale 1ns/1ps

module lsq_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  lsq_op_pkg::mem_op_e            dispatch_op,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  lq_alloc_idx,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  sq_alloc_idx,
  output logic                           lq_ready,
  output logic                           sq_ready,
  input  logic                           st_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  st_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_cfg_pkg::DATA_W-1:0] st_exec_data,
  input  logic                           ld_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  ld_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_exec_addr,
  output logic                           fwd_hit,
  output logic [lsq_cfg_pkg::DATA_W-1:0] fwd_data,
  output logic                           mem_rd_en,
  output logic [lsq_cfg_pkg::ADDR_W-1:0] mem_rd_addr,
  output logic                           mem_wr_en,
  output logic [lsq_cfg_pkg::ADDR_W-1:0] mem_wr_addr,
  output logic [lsq_cfg_pkg::DATA_W-1:0] mem_wr_data,
  output logic                           violation,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  violation_lq_idx,
  input  logic                           retire_valid,
  input  lsq_op_pkg::mem_op_e            retire_op,
  input  logic                           rollback_en,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_lq_tail,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_sq_tail
);

  import lsq_cfg_pkg::*;

  // Store queue state seen by the load queue and back
  logic [PTR_W-1:0] sq_head;
  logic [PTR_W-1:0] ld_store_bound;

  store_queue sq_i (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_op      (dispatch_op),
    .st_exec_valid    (st_exec_valid),
    .st_exec_idx      (st_exec_idx),
    .st_exec_addr     (st_exec_addr),
    .st_exec_data     (st_exec_data),
    .ld_exec_valid    (ld_exec_valid),
    .ld_exec_addr     (ld_exec_addr),
    .ld_store_bound   (ld_store_bound),
    .retire_valid     (retire_valid),
    .retire_op        (retire_op),
    .rollback_en      (rollback_en),
    .rollback_sq_tail (rollback_sq_tail),
    .sq_alloc_idx     (sq_alloc_idx),
    .sq_ready         (sq_ready),
    .sq_head          (sq_head),
    .fwd_hit          (fwd_hit),
    .fwd_data         (fwd_data),
    .mem_rd_en        (mem_rd_en),
    .mem_rd_addr      (mem_rd_addr),
    .mem_wr_en        (mem_wr_en),
    .mem_wr_addr      (mem_wr_addr),
    .mem_wr_data      (mem_wr_data)
  );

  load_queue lq_i (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_op      (dispatch_op),
    .sq_alloc_idx     (sq_alloc_idx),
    .ld_exec_valid    (ld_exec_valid),
    .ld_exec_idx      (ld_exec_idx),
    .ld_exec_addr     (ld_exec_addr),
    .st_exec_valid    (st_exec_valid),
    .st_exec_idx      (st_exec_idx),
    .st_exec_addr     (st_exec_addr),
    .sq_head          (sq_head),
    .retire_valid     (retire_valid),
    .retire_op        (retire_op),
    .rollback_en      (rollback_en),
    .rollback_lq_tail (rollback_lq_tail),
    .lq_alloc_idx     (lq_alloc_idx),
    .lq_ready         (lq_ready),
    .ld_store_bound   (ld_store_bound),
    .violation        (violation),
    .violation_lq_idx (violation_lq_idx)
  );

endmodule

// ==== verification/lsq_checker.sv ====
`timescale 1ns/1ps

module lsq_checker (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  lsq_op_pkg::mem_op_e            dispatch_op,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  lq_alloc_idx,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  sq_alloc_idx,
  input  logic                           lq_ready,
  input  logic                           sq_ready,
  input  logic                           st_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  st_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_cfg_pkg::DATA_W-1:0] st_exec_data,
  input  logic                           ld_exec_valid,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  ld_exec_idx,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_exec_addr,
  input  logic                           fwd_hit,
  input  logic [lsq_cfg_pkg::DATA_W-1:0] fwd_data,
  input  logic                           mem_rd_en,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] mem_rd_addr,
  input  logic                           mem_wr_en,
  input  logic [lsq_cfg_pkg::ADDR_W-1:0] mem_wr_addr,
  input  logic [lsq_cfg_pkg::DATA_W-1:0] mem_wr_data,
  input  logic                           violation,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  violation_lq_idx,
  input  logic                           retire_valid,
  input  lsq_op_pkg::mem_op_e            retire_op,
  input  logic                           rollback_en,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_lq_tail,
  input  logic [lsq_cfg_pkg::PTR_W-1:0]  rollback_sq_tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  model_lq_head,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  model_lq_tail,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  model_sq_head,
  output logic [lsq_cfg_pkg::PTR_W-1:0]  model_sq_tail,
  output logic                           model_sq_head_filled,
  output int                             check_count,
  output int                             error_count
);

  import lsq_cfg_pkg::*;
  import lsq_op_pkg::*;

  logic               st_filled [NUM_ENTRIES];
  logic [WADDR_W-1:0] st_word   [NUM_ENTRIES];
  logic [DATA_W-1:0]  st_data   [NUM_ENTRIES];
  logic               ld_done   [NUM_ENTRIES];
  logic [WADDR_W-1:0] ld_word   [NUM_ENTRIES];
  logic [PTR_W-1:0]   ld_bound  [NUM_ENTRIES];
  logic               viol_due;
  logic [PTR_W-1:0]   viol_idx;

  assign model_sq_head_filled = st_filled[model_sq_head[IDX_W-1:0]];

  task automatic compare(input string what, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // Youngest live store to the same word that is older than the load
  function automatic logic find_store(input logic [PTR_W-1:0] bound,
                                      input logic [WADDR_W-1:0] word,
                                      output logic [DATA_W-1:0] value);
    logic [PTR_W-1:0] older;
    logic [PTR_W-1:0] live;
    logic [PTR_W-1:0] pos;
    older = bound - model_sq_head;
    live  = model_sq_tail - model_sq_head;
    value = '0;
    for (int age = NUM_ENTRIES - 1; age >= 0; age--) begin
      pos = model_sq_head + PTR_W'(age);
      if (age < older && age < live && st_filled[pos[IDX_W-1:0]] &&
          st_word[pos[IDX_W-1:0]] == word) begin
        value = st_data[pos[IDX_W-1:0]];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Oldest executed load to the same word that is younger than the store
  function automatic logic find_violation(input logic [PTR_W-1:0] st_idx,
                                          input logic [WADDR_W-1:0] word,
                                          output logic [PTR_W-1:0] idx);
    logic [PTR_W-1:0] st_age;
    logic [PTR_W-1:0] ld_age;
    logic [PTR_W-1:0] pos;
    st_age = st_idx - model_sq_head;
    idx    = '0;
    for (pos = model_lq_head; pos != model_lq_tail; pos = pos + 1'b1) begin
      ld_age = ld_bound[pos[IDX_W-1:0]] - model_sq_head;
      if (ld_done[pos[IDX_W-1:0]] && ld_word[pos[IDX_W-1:0]] == word && st_age < ld_age) begin
        idx = pos;
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  always @(posedge clock) begin : model
    logic [PTR_W-1:0]  lq_cnt;
    logic [PTR_W-1:0]  sq_cnt;
    logic              hit;
    logic              st_retire;
    logic [DATA_W-1:0] value;
    logic [IDX_W-1:0]  h;
    lq_cnt    = model_lq_tail - model_lq_head;
    sq_cnt    = model_sq_tail - model_sq_head;
    st_retire = retire_valid && retire_op == MEM_STORE;
    h         = model_sq_head[IDX_W-1:0];
    if (reset) begin
      model_lq_head = '0;
      model_lq_tail = '0;
      model_sq_head = '0;
      model_sq_tail = '0;
      viol_due      = 1'b0;
      check_count   = 0;
      error_count   = 0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        st_filled[i] = 1'b0;
        ld_done[i]   = 1'b0;
      end
    end else begin
      compare("violation", violation, viol_due);
      if (viol_due) begin
        compare("violation_lq_idx", violation_lq_idx, viol_idx);
      end
      compare("lq_alloc_idx", lq_alloc_idx, model_lq_tail);
      compare("sq_alloc_idx", sq_alloc_idx, model_sq_tail);
      compare("lq_ready", lq_ready, lq_cnt != NUM_ENTRIES);
      compare("sq_ready", sq_ready, sq_cnt != NUM_ENTRIES);

      hit = 1'b0;
      if (ld_exec_valid) begin
        hit = find_store(ld_bound[ld_exec_idx[IDX_W-1:0]], ld_exec_addr[ADDR_W-1:WORD_LSB],
                         value);
      end
      compare("fwd_hit", fwd_hit, hit);
      if (hit) begin
        compare("fwd_data", fwd_data, value);
      end
      compare("mem_rd_en", mem_rd_en, ld_exec_valid && !hit);
      if (ld_exec_valid && !hit) begin
        compare("mem_rd_addr", mem_rd_addr, ld_exec_addr);
      end
      compare("mem_wr_en", mem_wr_en, st_retire);
      if (st_retire) begin
        compare("mem_wr_addr", mem_wr_addr, {st_word[h], {WORD_LSB{1'b0}}});
        compare("mem_wr_data", mem_wr_data, st_data[h]);
      end

      // Seen one edge later on the DUT
      viol_due = st_exec_valid &&
                 find_violation(st_exec_idx, st_exec_addr[ADDR_W-1:WORD_LSB], viol_idx);

      if (st_exec_valid) begin
        st_filled[st_exec_idx[IDX_W-1:0]] = 1'b1;
        st_word[st_exec_idx[IDX_W-1:0]]   = st_exec_addr[ADDR_W-1:WORD_LSB];
        st_data[st_exec_idx[IDX_W-1:0]]   = st_exec_data;
      end
      if (ld_exec_valid) begin
        ld_done[ld_exec_idx[IDX_W-1:0]] = 1'b1;
        ld_word[ld_exec_idx[IDX_W-1:0]] = ld_exec_addr[ADDR_W-1:WORD_LSB];
      end
      if (st_retire && sq_cnt != 0) begin
        model_sq_head = model_sq_head + 1'b1;
      end
      if (retire_valid && retire_op == MEM_LOAD && lq_cnt != 0) begin
        model_lq_head = model_lq_head + 1'b1;
      end
      if (rollback_en) begin
        model_lq_tail = rollback_lq_tail;
        model_sq_tail = rollback_sq_tail;
      end else if (dispatch_valid && dispatch_op == MEM_LOAD && lq_cnt != NUM_ENTRIES) begin
        ld_done[model_lq_tail[IDX_W-1:0]]  = 1'b0;
        ld_bound[model_lq_tail[IDX_W-1:0]] = model_sq_tail;
        model_lq_tail = model_lq_tail + 1'b1;
      end else if (dispatch_valid && dispatch_op == MEM_STORE && sq_cnt != NUM_ENTRIES) begin
        st_filled[model_sq_tail[IDX_W-1:0]] = 1'b0;
        model_sq_tail = model_sq_tail + 1'b1;
      end
    end
  end

endmodule

// ==== verification/tb_lsq.sv ====
`timescale 1ns/1ps

module tb_lsq;

  import lsq_cfg_pkg::*;
  import lsq_op_pkg::*;

  localparam int SEED            = 32'h133d_bf10;
  localparam int RESET_CYCLES    = 10;
  localparam int FILL_CYCLES     = 24;
  localparam int DRAIN_CYCLES    = 60;
  localparam int FWD_CYCLES      = 200;
  localparam int VIOL_CYCLES     = 200;
  localparam int RETIRE_CYCLES   = 150;
  localparam int ROLLBACK_CYCLES = 300;
  localparam int RUN_LIMIT       = RESET_CYCLES + FILL_CYCLES + DRAIN_CYCLES + FWD_CYCLES +
                                   VIOL_CYCLES + RETIRE_CYCLES + ROLLBACK_CYCLES + 100;

  logic              clock;
  logic              reset;
  logic              dispatch_valid;
  mem_op_e           dispatch_op;
  logic [PTR_W-1:0]  lq_alloc_idx;
  logic [PTR_W-1:0]  sq_alloc_idx;
  logic              lq_ready;
  logic              sq_ready;
  logic              st_exec_valid;
  logic [PTR_W-1:0]  st_exec_idx;
  logic [ADDR_W-1:0] st_exec_addr;
  logic [DATA_W-1:0] st_exec_data;
  logic              ld_exec_valid;
  logic [PTR_W-1:0]  ld_exec_idx;
  logic [ADDR_W-1:0] ld_exec_addr;
  logic              fwd_hit;
  logic [DATA_W-1:0] fwd_data;
  logic              mem_rd_en;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic              mem_wr_en;
  logic [ADDR_W-1:0] mem_wr_addr;
  logic [DATA_W-1:0] mem_wr_data;
  logic              violation;
  logic [PTR_W-1:0]  violation_lq_idx;
  logic              retire_valid;
  mem_op_e           retire_op;
  logic              rollback_en;
  logic [PTR_W-1:0]  rollback_lq_tail;
  logic [PTR_W-1:0]  rollback_sq_tail;
  logic [PTR_W-1:0]  model_lq_head;
  logic [PTR_W-1:0]  model_lq_tail;
  logic [PTR_W-1:0]  model_sq_head;
  logic [PTR_W-1:0]  model_sq_tail;
  logic              model_sq_head_filled;
  logic [PTR_W-1:0]  saved_lq_tail;
  logic [PTR_W-1:0]  saved_sq_tail;
  int                check_count;
  int                error_count;
  int                last_checks;
  int                last_errors;
  int                tests_run;
  int                tests_failed;
  int                cycle_count;

  lsq_top dut_i (.*);

  lsq_checker chk_i (.*);

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < RUN_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", RUN_LIMIT);
    $display("Test failed");
    $finish;
  end

  task automatic idle_inputs();
    dispatch_valid   = 1'b0;
    dispatch_op      = MEM_NONE;
    st_exec_valid    = 1'b0;
    st_exec_idx      = '0;
    st_exec_addr     = '0;
    st_exec_data     = '0;
    ld_exec_valid    = 1'b0;
    ld_exec_idx      = '0;
    ld_exec_addr     = '0;
    retire_valid     = 1'b0;
    retire_op        = MEM_NONE;
    rollback_en      = 1'b0;
    rollback_lq_tail = '0;
    rollback_sq_tail = '0;
  endtask

  // Four words with random byte offsets so addresses collide
  function automatic logic [ADDR_W-1:0] pick_addr();
    return 32'h0000_1000 + (($urandom % 4) << WORD_LSB) + ($urandom % 4);
  endfunction

  // One cycle of legal random traffic with weights in percent
  task automatic drive_cycle(input int p_disp, input int p_exec, input int p_ret,
                             input int p_rb);
    logic [PTR_W-1:0] lq_cnt;
    logic [PTR_W-1:0] sq_cnt;
    logic             ld_ok;
    logic             st_ok;
    @(negedge clock);
    idle_inputs();
    lq_cnt = model_lq_tail - model_lq_head;
    sq_cnt = model_sq_tail - model_sq_head;
    rollback_en = $urandom % 100 < p_rb &&
                  PTR_W'(saved_lq_tail - model_lq_head) <= lq_cnt &&
                  PTR_W'(saved_sq_tail - model_sq_head) <= sq_cnt;
    rollback_lq_tail = saved_lq_tail;
    rollback_sq_tail = saved_sq_tail;
    if (!rollback_en && $urandom % 100 < 10) begin
      // Branch point
      saved_lq_tail = model_lq_tail;
      saved_sq_tail = model_sq_tail;
    end
    if ($urandom % 100 < p_disp && (lq_cnt != NUM_ENTRIES || sq_cnt != NUM_ENTRIES)) begin
      dispatch_valid = 1'b1;
      dispatch_op    = ($urandom % 2 == 0) ? MEM_LOAD : MEM_STORE;
      if (lq_cnt == NUM_ENTRIES) begin
        dispatch_op = MEM_STORE;
      end else if (sq_cnt == NUM_ENTRIES) begin
        dispatch_op = MEM_LOAD;
      end
    end
    if (lq_cnt != 0 && $urandom % 100 < p_exec) begin
      ld_exec_valid = 1'b1;
      ld_exec_idx   = model_lq_head + PTR_W'($urandom % lq_cnt);
      ld_exec_addr  = pick_addr();
    end
    if (sq_cnt != 0 && $urandom % 100 < p_exec) begin
      st_exec_valid = 1'b1;
      st_exec_idx   = model_sq_head + PTR_W'($urandom % sq_cnt);
      st_exec_addr  = pick_addr();
      st_exec_data  = $urandom;
    end
    // Stores leave only once their address is known
    ld_ok = lq_cnt != 0;
    st_ok = sq_cnt != 0 && model_sq_head_filled;
    if (!rollback_en && (ld_ok || st_ok) && $urandom % 100 < p_ret) begin
      retire_valid = 1'b1;
      retire_op    = (st_ok && (!ld_ok || $urandom % 2 == 0)) ? MEM_STORE : MEM_LOAD;
    end
  endtask

  task automatic run_cycles(input int n, input int p_disp, input int p_exec,
                            input int p_ret, input int p_rb);
    for (int i = 0; i < n; i++) begin
      drive_cycle(p_disp, p_exec, p_ret, p_rb);
    end
  endtask

  task automatic end_test(input string name);
    int new_errors;
    // Idle until the last cycle and its registered violation are checked
    @(negedge clock);
    idle_inputs();
    @(negedge clock);
    new_errors = error_count - last_errors;
    tests_run++;
    if (new_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d checks, %0d mismatches", name, check_count - last_checks,
             new_errors);
    last_checks = check_count;
    last_errors = error_count;
  endtask

  initial begin
    void'($urandom(SEED));
    saved_lq_tail = '0;
    saved_sq_tail = '0;
    last_checks   = 0;
    last_errors   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    idle_inputs();
    reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    run_cycles(FILL_CYCLES, 100, 0, 0, 0);
    run_cycles(DRAIN_CYCLES, 0, 100, 100, 0);
    end_test("fill and drain");
    run_cycles(FWD_CYCLES, 40, 70, 10, 0);
    end_test("forwarding");
    run_cycles(VIOL_CYCLES, 40, 95, 10, 0);
    end_test("violation");
    run_cycles(RETIRE_CYCLES, 50, 60, 50, 0);
    end_test("retire");
    run_cycles(ROLLBACK_CYCLES, 50, 60, 25, 8);
    end_test("rollback");

    $display("%0d tests, %0d failed, %0d checks, %0d mismatches", tests_run, tests_failed,
             check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/lsq_cfg_pkg.sv
design/lsq_op_pkg.sv
design/queue_pointers.sv
design/store_queue.sv
design/load_queue.sv
design/lsq_top.sv
verification/lsq_checker.sv
verification/tb_lsq.sv

// ==== Bender.yml ====
package:
  name: lsq

sources:
  - design/lsq_cfg_pkg.sv
  - design/lsq_op_pkg.sv
  - design/queue_pointers.sv
  - design/store_queue.sv
  - design/load_queue.sv
  - design/lsq_top.sv
  - target: simulation
    files:
      - verification/lsq_checker.sv
      - verification/tb_lsq.sv
